// ==== common/dp_pkg.sv ====
`default_nettype none

package dp_pkg;

	localparam int xlen = 32;
	localparam int reg_count = 32;
	localparam int regidx_w = 5;
	localparam int shamt_w = 5;
	localparam int irq_timer_bit = 0;

	typedef enum logic [3:0] {
		op_lui,
		op_addi,
		op_sll,
		op_srl,
		op_sra,
		op_slli,
		op_srli,
		op_srai,
		op_rdinstr,
		op_maskirq,
		op_timer,
		op_waitirq
	} dp_op_e;

	typedef enum logic [2:0] {
		st_idle,
		st_ld_rs,
		st_exec,
		st_shift,
		st_wait_irq,
		st_writeback
	} dp_state_e;

	typedef enum logic [1:0] {
		sh_sll,
		sh_srl,
		sh_sra
	} shift_dir_e;

	// rs2 doubles as the shift amount of the immediate forms
	typedef struct packed {
		dp_op_e op;
		logic [regidx_w-1:0] rd;
		logic [regidx_w-1:0] rs1;
		logic [regidx_w-1:0] rs2;
		logic [xlen-1:0] imm;
	} dp_cmd_t;

	typedef struct packed {
		logic valid;
		logic [regidx_w-1:0] rd;
		logic [xlen-1:0] data;
	} wb_t;

endpackage

`default_nettype wire

// ==== irq/irq_timer.sv ====
`default_nettype none

module irq_timer
	import dp_pkg::*;
(
	input wire clk,
	input wire resetn,
	input wire [xlen-1:0] irq,
	input wire set_mask,
	input wire set_timer,
	input wire take_irq,
	input wire [xlen-1:0] wdata,
	output logic [xlen-1:0] old_mask,
	output logic [xlen-1:0] old_timer,
	output logic [xlen-1:0] pending_unmasked,
	output logic [xlen-1:0] eoi
);

	logic [xlen-1:0] mask_q;
	logic [xlen-1:0] pending_q;
	logic [xlen-1:0] timer_q;
	logic [xlen-1:0] pending_next;

	assign old_mask = mask_q;
	assign old_timer = timer_q;
	// masked bits stay pending
	assign pending_unmasked = pending_q & ~mask_q;
	assign eoi = take_irq ? pending_unmasked : '0;

	always_comb begin
		if (take_irq) begin
			pending_next = pending_q & ~pending_unmasked;
		end else begin
			pending_next = pending_q;
		end
		// new requests survive a take in the same cycle
		pending_next = pending_next | irq;
		if (timer_q == xlen'(1)) begin
			pending_next[irq_timer_bit] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			mask_q <= '1;
			pending_q <= '0;
			timer_q <= '0;
		end else begin
			pending_q <= pending_next;
			if (set_mask) begin
				mask_q <= wdata;
			end
			if (set_timer) begin
				timer_q <= wdata;
			end else if (timer_q != '0) begin
				timer_q <= timer_q - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+tests
common/dp_pkg.sv
source/reg_file.sv
shift/shift_unit.sv
irq/irq_timer.sv
source/exec_ctrl.sv
source/dp_top.sv
tests/tb_clock.sv
tests/tb_dp.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the datapath testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dp -f project.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_dp > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0

// ==== shift/shift_unit.sv ====
`default_nettype none

module shift_unit
	import dp_pkg::*;
(
	input wire clk,
	input wire resetn,
	input wire shift_start,
	input wire shift_dir_e shift_dir,
	input wire [xlen-1:0] shift_val,
	input wire [shamt_w-1:0] shift_amt,
	output logic shift_done,
	output logic [xlen-1:0] shift_res
);

	logic active_q;
	logic [shamt_w-1:0] cnt_q;
	shift_dir_e dir_q;
	logic [xlen-1:0] val_q;
	logic big_step;

	function automatic logic [xlen-1:0] step(input logic [xlen-1:0] v, input shift_dir_e d,
			input logic by4);
		logic [shamt_w-1:0] n;
		n = by4 ? shamt_w'(4) : shamt_w'(1);
		case (d)
			sh_srl: step = v >> n;
			sh_sra: step = $signed(v) >>> n;
			default: step = v << n;
		endcase
	endfunction

	assign big_step = cnt_q >= shamt_w'(4);
	assign shift_done = active_q && cnt_q == '0;
	assign shift_res = val_q;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active_q <= 1'b0;
			cnt_q <= '0;
		end else if (shift_start) begin
			active_q <= 1'b1;
			cnt_q <= shift_amt;
		end else if (active_q) begin
			if (cnt_q == '0) begin
				active_q <= 1'b0;
			end else if (big_step) begin
				cnt_q <= cnt_q - shamt_w'(4);
			end else begin
				cnt_q <= cnt_q - shamt_w'(1);
			end
		end
	end

	// operand path
	always_ff @(posedge clk) begin
		if (shift_start) begin
			val_q <= shift_val;
			dir_q <= shift_dir;
		end else if (active_q && cnt_q != '0) begin
			val_q <= step(val_q, dir_q, big_step);
		end
	end

endmodule

`default_nettype wire

// ==== source/dp_top.sv ====
`default_nettype none

module dp_top
	import dp_pkg::*;
(
	input wire clk,
	input wire resetn,
	input wire start,
	input wire dp_cmd_t cmd,
	input wire [xlen-1:0] irq,
	output logic busy,
	output wb_t wb,
	output logic [xlen-1:0] eoi
);

	logic [regidx_w-1:0] rs1_addr;
	logic [regidx_w-1:0] rs2_addr;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;

	logic shift_start;
	shift_dir_e shift_dir;
	logic [xlen-1:0] shift_val;
	logic [shamt_w-1:0] shift_amt;
	logic shift_done;
	logic [xlen-1:0] shift_res;

	logic set_mask;
	logic set_timer;
	logic take_irq;
	logic [xlen-1:0] wdata;
	logic [xlen-1:0] old_mask;
	logic [xlen-1:0] old_timer;
	logic [xlen-1:0] pending_unmasked;

	reg_file reg_file_i (
		.clk(clk),
		.resetn(resetn),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.wr(wb),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	exec_ctrl exec_ctrl_i (
		.clk(clk),
		.resetn(resetn),
		.start(start),
		.cmd(cmd),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.shift_done(shift_done),
		.shift_res(shift_res),
		.old_mask(old_mask),
		.old_timer(old_timer),
		.pending_unmasked(pending_unmasked),
		.busy(busy),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.shift_start(shift_start),
		.shift_dir(shift_dir),
		.shift_val(shift_val),
		.shift_amt(shift_amt),
		.set_mask(set_mask),
		.set_timer(set_timer),
		.take_irq(take_irq),
		.wdata(wdata),
		.wb(wb)
	);

	shift_unit shift_unit_i (
		.clk(clk),
		.resetn(resetn),
		.shift_start(shift_start),
		.shift_dir(shift_dir),
		.shift_val(shift_val),
		.shift_amt(shift_amt),
		.shift_done(shift_done),
		.shift_res(shift_res)
	);

	irq_timer irq_timer_i (
		.clk(clk),
		.resetn(resetn),
		.irq(irq),
		.set_mask(set_mask),
		.set_timer(set_timer),
		.take_irq(take_irq),
		.wdata(wdata),
		.old_mask(old_mask),
		.old_timer(old_timer),
		.pending_unmasked(pending_unmasked),
		.eoi(eoi)
	);

endmodule

`default_nettype wire

// ==== source/exec_ctrl.sv ====
`default_nettype none

module exec_ctrl
	import dp_pkg::*;
(
	input wire clk,
	input wire resetn,
	input wire start,
	input wire dp_cmd_t cmd,
	input wire [xlen-1:0] rs1_data,
	input wire [xlen-1:0] rs2_data,
	input wire shift_done,
	input wire [xlen-1:0] shift_res,
	input wire [xlen-1:0] old_mask,
	input wire [xlen-1:0] old_timer,
	input wire [xlen-1:0] pending_unmasked,
	output logic busy,
	output logic [regidx_w-1:0] rs1_addr,
	output logic [regidx_w-1:0] rs2_addr,
	output logic shift_start,
	output shift_dir_e shift_dir,
	output logic [xlen-1:0] shift_val,
	output logic [shamt_w-1:0] shift_amt,
	output logic set_mask,
	output logic set_timer,
	output logic take_irq,
	output logic [xlen-1:0] wdata,
	output wb_t wb
);

	dp_state_e state_q;
	dp_cmd_t cmd_q;
	logic [xlen-1:0] op1_q;
	logic [xlen-1:0] op2_q;
	logic [xlen-1:0] res_q;
	logic [xlen-1:0] instr_cnt_q;
	logic accept;
	logic is_shift;
	logic is_reg_shift;

	// a new op may be taken in the writeback cycle
	assign busy = state_q != st_idle && state_q != st_writeback;
	assign accept = start && !busy;

	assign is_reg_shift = cmd_q.op inside {op_sll, op_srl, op_sra};
	assign is_shift = is_reg_shift || cmd_q.op inside {op_slli, op_srli, op_srai};

	always_comb begin
		case (cmd_q.op)
			op_srl, op_srli: shift_dir = sh_srl;
			op_sra, op_srai: shift_dir = sh_sra;
			default: shift_dir = sh_sll;
		endcase
	end

	assign rs1_addr = cmd_q.rs1;
	assign rs2_addr = cmd_q.rs2;

	assign shift_start = state_q == st_exec && is_shift;
	assign shift_val = op1_q;
	assign shift_amt = is_reg_shift ? op2_q[shamt_w-1:0] : cmd_q.rs2;

	assign set_mask = state_q == st_exec && cmd_q.op == op_maskirq;
	assign set_timer = state_q == st_exec && cmd_q.op == op_timer;
	assign take_irq = state_q == st_wait_irq && |pending_unmasked;
	assign wdata = op1_q;

	always_comb begin
		wb.valid = state_q == st_writeback;
		wb.rd = cmd_q.rd;
		wb.data = res_q;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= st_idle;
			instr_cnt_q <= '0;
		end else begin
			case (state_q)
				st_ld_rs: state_q <= st_exec;
				st_exec: begin
					if (is_shift) begin
						state_q <= st_shift;
					end else if (cmd_q.op == op_waitirq) begin
						state_q <= st_wait_irq;
					end else begin
						state_q <= st_writeback;
					end
				end
				st_shift: begin
					if (shift_done) begin
						state_q <= st_writeback;
					end
				end
				st_wait_irq: begin
					if (take_irq) begin
						state_q <= st_writeback;
					end
				end
				st_writeback: begin
					// retire
					instr_cnt_q <= instr_cnt_q + 1'b1;
					state_q <= accept ? st_ld_rs : st_idle;
				end
				default: begin
					if (accept) begin
						state_q <= st_ld_rs;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_q <= cmd;
		end
		if (state_q == st_ld_rs) begin
			op1_q <= rs1_data;
			op2_q <= rs2_data;
		end
		case (state_q)
			st_exec: begin
				case (cmd_q.op)
					op_lui: res_q <= cmd_q.imm;
					op_addi: res_q <= op1_q + cmd_q.imm;
					op_rdinstr: res_q <= instr_cnt_q;
					op_maskirq: res_q <= old_mask;
					op_timer: res_q <= old_timer;
					default: res_q <= op1_q;
				endcase
			end
			st_shift: begin
				if (shift_done) begin
					res_q <= shift_res;
				end
			end
			st_wait_irq: begin
				if (take_irq) begin
					res_q <= pending_unmasked;
				end
			end
			default: res_q <= res_q;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`default_nettype none

module reg_file
	import dp_pkg::*;
(
	input wire clk,
	input wire resetn,
	input wire [regidx_w-1:0] rs1_addr,
	input wire [regidx_w-1:0] rs2_addr,
	input wire wb_t wr,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data
);

	logic [xlen-1:0] regs [reg_count];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid && wr.rd != '0) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// x0 reads as zero
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none

module tb_clock (
	output logic clk,
	output logic resetn
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ten cycles of reset, released on a falling edge
	initial begin
		resetn = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tests/tb_table.svh ====
// one row per command, sweep rows repeat once for each entry of shift_amts
// columns: op, rd, rs1, rs2, imm, irq pulse, expected, flags
localparam logic [3:0] f_rnd = 4'b0001;
localparam logic [3:0] f_fix = 4'b0010;
localparam logic [3:0] f_sweep = 4'b0100;
localparam logic [3:0] f_poke = 4'b1000;
localparam int row_count = 37;

int shift_amts [6] = '{0, 1, 3, 4, 7, 31};

row_t rows [row_count] = '{
	'{op_lui,     5'd1,  5'd0,  5'd0,  32'h0,        32'h0,     32'h0,   f_rnd},
	'{op_lui,     5'd2,  5'd0,  5'd0,  32'h0,        32'h0,     32'h0,   f_rnd},
	'{op_addi,    5'd3,  5'd1,  5'd0,  32'h0,        32'h0,     32'h0,   f_rnd},
	'{op_addi,    5'd4,  5'd2,  5'd0,  32'h0,        32'h0,     32'h0,   f_rnd},
	'{op_lui,     5'd0,  5'd0,  5'd0,  32'h0,        32'h0,     32'h0,   f_rnd},
	'{op_addi,    5'd5,  5'd0,  5'd0,  32'h0,        32'h0,     32'h0,   4'b0000},
	'{op_addi,    5'd6,  5'd1,  5'd0,  32'h0,        32'h0,     32'h0,   4'b0000},
	'{op_addi,    5'd7,  5'd2,  5'd0,  32'h0,        32'h0,     32'h0,   4'b0000},
	'{op_addi,    5'd9,  5'd3,  5'd0,  32'h0,        32'h0,     32'h0,   4'b0000},
	'{op_addi,    5'd9,  5'd4,  5'd0,  32'h0,        32'h0,     32'h0,   4'b0000},
	'{op_lui,     5'd8,  5'd0,  5'd0,  32'h8765_4321, 32'h0,    32'h0,   4'b0000},
	// shift amounts for the register forms
	'{op_addi,    5'd10, 5'd0,  5'd0,  32'd0,        32'h0,     32'h0,   4'b0000},
	'{op_addi,    5'd11, 5'd0,  5'd0,  32'd1,        32'h0,     32'h0,   4'b0000},
	'{op_addi,    5'd12, 5'd0,  5'd0,  32'd3,        32'h0,     32'h0,   4'b0000},
	'{op_addi,    5'd13, 5'd0,  5'd0,  32'd4,        32'h0,     32'h0,   4'b0000},
	'{op_addi,    5'd14, 5'd0,  5'd0,  32'd7,        32'h0,     32'h0,   4'b0000},
	'{op_addi,    5'd15, 5'd0,  5'd0,  32'd31,       32'h0,     32'h0,   4'b0000},
	'{op_rdinstr, 5'd16, 5'd0,  5'd0,  32'h0,        32'h0,     32'h0,   4'b0000},
	'{op_sll,     5'd17, 5'd8,  5'd10, 32'h0,        32'h0,     32'h0,   f_sweep},
	'{op_srl,     5'd17, 5'd8,  5'd10, 32'h0,        32'h0,     32'h0,   f_sweep},
	'{op_sra,     5'd17, 5'd8,  5'd10, 32'h0,        32'h0,     32'h0,   f_sweep},
	'{op_slli,    5'd17, 5'd8,  5'd0,  32'h0,        32'h0,     32'h0,   f_sweep},
	'{op_srli,    5'd17, 5'd8,  5'd0,  32'h0,        32'h0,     32'h0,   f_sweep},
	'{op_srai,    5'd17, 5'd8,  5'd0,  32'h0,        32'h0,     32'h0,   f_sweep},
	'{op_sra,     5'd18, 5'd8,  5'd15, 32'h0,        32'h0,     32'h0,   f_poke},
	'{op_addi,    5'd19, 5'd1,  5'd0,  32'h0,        32'h0,     32'h0,   4'b0000},
	'{op_rdinstr, 5'd16, 5'd0,  5'd0,  32'h0,        32'h0,     32'h0,   4'b0000},
	// irq 0 and 4..7 open, the rest masked
	'{op_lui,     5'd20, 5'd0,  5'd0,  32'hffff_ff0e, 32'h0,    32'h0,   4'b0000},
	'{op_maskirq, 5'd21, 5'd20, 5'd0,  32'h0,        32'h0,     32'h0,   4'b0000},
	'{op_addi,    5'd22, 5'd0,  5'd0,  32'h0,        32'h0ff0,  32'h0,   4'b0000},
	'{op_waitirq, 5'd23, 5'd0,  5'd0,  32'h0,        32'h0,     32'hf0,  f_fix},
	'{op_addi,    5'd24, 5'd0,  5'd0,  32'd20,       32'h0,     32'h0,   4'b0000},
	'{op_timer,   5'd25, 5'd24, 5'd0,  32'h0,        32'h0,     32'h0,   f_fix},
	'{op_waitirq, 5'd26, 5'd0,  5'd0,  32'h0,        32'h0,     32'h1,   f_fix},
	'{op_timer,   5'd27, 5'd0,  5'd0,  32'h0,        32'h0,     32'h0,   f_fix},
	'{op_maskirq, 5'd28, 5'd0,  5'd0,  32'h0,        32'h0,     32'h0,   4'b0000},
	'{op_rdinstr, 5'd29, 5'd0,  5'd0,  32'h0,        32'h0,     32'h0,   4'b0000}
};

// ==== tests/tb_dp.sv ====
`default_nettype none

module tb_dp
	import dp_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		dp_op_e op;
		logic [regidx_w-1:0] rd;
		logic [regidx_w-1:0] rs1;
		logic [regidx_w-1:0] rs2;
		logic [xlen-1:0] imm;
		logic [xlen-1:0] irq;
		logic [xlen-1:0] exp;
		logic [3:0] flags;
	} row_t;

	`include "tb_table.svh"

	// command pulsed while the DUT is busy
	localparam dp_cmd_t poke_cmd = '{op: op_lui, rd: 5'd1, rs1: 5'd0, rs2: 5'd0,
		imm: 32'hdead_beef};

	logic clk;
	logic resetn;
	logic start;
	dp_cmd_t cmd;
	logic [xlen-1:0] irq;
	logic busy;
	wb_t wb;
	logic [xlen-1:0] eoi;

	logic [xlen-1:0] model_regs [reg_count] = '{default: '0};
	logic [xlen-1:0] model_mask = '1;
	logic [31:0] lfsr_state = 32'd90777;
	int retired = 0;
	int errors = 0;

	tb_clock tb_clock_i (
		.clk(clk),
		.resetn(resetn)
	);

	dp_top dp_top_i (
		.clk(clk),
		.resetn(resetn),
		.start(start),
		.cmd(cmd),
		.irq(irq),
		.busy(busy),
		.wb(wb),
		.eoi(eoi)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'ha300_0000;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit
	function automatic logic [xlen-1:0] rand_word();
		logic [xlen-1:0] w;
		w = '0;
		for (int i = 0; i < xlen; i++) begin
			w = {w[xlen-2:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return w;
	endfunction

	function automatic int op_total();
		int n;
		n = 0;
		for (int r = 0; r < row_count; r++) begin
			n += ((rows[r].flags & f_sweep) != '0) ? 6 : 1;
		end
		return n;
	endfunction

	// reference result from the register model
	function automatic logic [xlen-1:0] expect_of(input dp_cmd_t c);
		logic [xlen-1:0] a;
		logic [shamt_w-1:0] sh;
		a = model_regs[c.rs1];
		sh = (c.op inside {op_sll, op_srl, op_sra}) ? model_regs[c.rs2][shamt_w-1:0] : c.rs2;
		case (c.op)
			op_lui: return c.imm;
			op_addi: return a + c.imm;
			op_sll, op_slli: return a << sh;
			op_srl, op_srli: return a >> sh;
			op_sra, op_srai: return $signed(a) >>> sh;
			op_rdinstr: return xlen'(retired);
			op_maskirq: return model_mask;
			default: return '0;
		endcase
	endfunction

	task automatic retire(input dp_cmd_t c, input logic [xlen-1:0] v);
		if (c.op == op_maskirq) begin
			model_mask = model_regs[c.rs1];
		end
		if (c.rd != '0) begin
			model_regs[c.rd] = v;
		end
		retired++;
	endtask

	task automatic run_op(input dp_cmd_t c, input logic [xlen-1:0] irq_val, input bit poke,
			output wb_t got, output logic [xlen-1:0] eoi_seen, output int cycles);
		bit done;
		done = 1'b0;
		got = '0;
		eoi_seen = '0;
		cycles = 0;
		@(negedge clk);
		if (busy !== 1'b0 || wb.valid !== 1'b0) begin
			errors++;
			$display("the DUT was not idle before a start");
		end
		cmd = c;
		start = 1'b1;
		irq = irq_val;
		while (!done) begin
			@(negedge clk);
			start = 1'b0;
			irq = '0;
			cycles++;
			if (eoi != '0) begin
				eoi_seen = eoi;
			end
			if (wb.valid) begin
				got = wb;
				done = 1'b1;
				if (busy !== 1'b0) begin
					errors++;
					$display("ERR busy in writeback cycle: got %h expected %h", busy, 1'b0);
				end
			end else begin
				if (busy !== 1'b1) begin
					errors++;
					$display("ERR busy before writeback: got %h expected %h", busy, 1'b1);
				end
				if (poke && cycles == 2 && busy) begin
					cmd = poke_cmd;
					start = 1'b1;
				end
			end
		end
	endtask

	initial begin
		dp_cmd_t c;
		wb_t got;
		logic [xlen-1:0] exp;
		logic [xlen-1:0] exp_eoi;
		logic [xlen-1:0] eoi_seen;
		int cycles;
		int reps;
		bit poke;
		start = 1'b0;
		cmd = '0;
		irq = '0;
		wait (resetn === 1'b1);
		if (busy !== 1'b0 || wb.valid !== 1'b0 || eoi !== '0) begin
			errors++;
			$display("outputs are not idle after reset");
		end
		for (int r = 0; r < row_count; r++) begin
			reps = ((rows[r].flags & f_sweep) != '0) ? 6 : 1;
			for (int k = 0; k < reps; k++) begin
				c.op = rows[r].op;
				c.rd = rows[r].rd;
				c.rs1 = rows[r].rs1;
				c.rs2 = rows[r].rs2;
				c.imm = rows[r].imm;
				if ((rows[r].flags & f_sweep) != '0) begin
					if (c.op inside {op_sll, op_srl, op_sra}) begin
						c.rs2 = regidx_w'(rows[r].rs2 + k);
					end else begin
						c.rs2 = regidx_w'(shift_amts[k]);
					end
				end
				if ((rows[r].flags & f_rnd) != '0) begin
					c.imm = rand_word();
				end
				poke = (rows[r].flags & f_poke) != '0;
				exp = ((rows[r].flags & f_fix) != '0) ? rows[r].exp : expect_of(c);
				exp_eoi = (c.op == op_waitirq) ? exp : '0;
				run_op(c, rows[r].irq, poke, got, eoi_seen, cycles);
				if (got.rd !== c.rd) begin
					errors++;
					$display("ERR op %0d wb.rd: got %h expected %h", retired, got.rd, c.rd);
				end
				if (got.data !== exp) begin
					errors++;
					$display("ERR op %0d wb.data: got %h expected %h", retired, got.data, exp);
				end
				if (eoi_seen !== exp_eoi) begin
					errors++;
					$display("ERR op %0d eoi: got %h expected %h", retired, eoi_seen, exp_eoi);
				end
				if (c.op inside {op_lui, op_addi, op_rdinstr, op_maskirq, op_timer} &&
						cycles != 3) begin
					errors++;
					$display("op %0d (%s) took %0d cycles instead of 3", retired,
						c.op.name(), cycles);
				end
				if (poke) begin
					repeat (4) begin
						@(negedge clk);
						if (wb.valid) begin
							errors++;
							$display("a start given while busy produced an extra writeback");
						end
					end
				end
				retire(c, exp);
			end
		end
		$display("%0d operations checked, %0d errors", retired, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// generous bound per operation
	initial begin
		repeat (10 + op_total() * 60) @(posedge clk);
		$display("watchdog expired after %0d operations, the DUT stopped responding", retired);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
